// File: bench/act_mem_checks.svh
`ifndef ACT_MEM_CHECKS_SVH
`define ACT_MEM_CHECKS_SVH

////////////////////////////////////////////////////////////
// result compares
////////////////////////////////////////////////////////////

task automatic stop_run();
	$display("Something failed");
	$fatal(1, "stopped at first error");
endtask

task automatic check_word(input act_word_pkg::act_word_u got,
	input act_word_pkg::act_word_u exp);
	if (got !== exp) begin
		$display("** Error at time %0t: read_word %h, expected %h", $time, got.raw, exp.raw);
		stop_run();
	end
endtask

task automatic check_resp(input act_word_pkg::act_word_u got, input logic got_err,
	input act_word_pkg::act_word_u exp, input logic exp_err);
	if (got !== exp || got_err !== exp_err) begin
		$display("** Error at time %0t: prdata %h pslverr %b, expected %h pslverr %b",
			$time, got.raw, got_err, exp.raw, exp_err);
		stop_run();
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
		stop_run();
	end
endtask

////////////////////////////////////////////////////////////
// apb master
////////////////////////////////////////////////////////////

// access phase runs until pready, sampled on the falling edge
task automatic wait_pready(input string what);
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (!pready) begin
		cycles++;
		if (cycles > wait_limit) begin
			$display("APB %s to address %h got no pready within %0d cycles",
				what, paddr, wait_limit);
			stop_run();
		end
		@(negedge clk);
	end
	@(posedge clk);                                     // transfer completes here
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b1;
	paddr   <= addr;
	pwdata  <= data;
	@(posedge clk);
	penable <= 1'b1;
	wait_pready("write");
endtask

task automatic apb_read(input logic [31:0] addr);
	@(posedge clk);
	psel    <= 1'b1;
	penable <= 1'b0;
	pwrite  <= 1'b0;
	paddr   <= addr;
	@(posedge clk);
	penable <= 1'b1;
	wait_pready("read");
endtask

`endif

// File: bench/act_mem_tb.sv
`include "act_mem_params.svh"

module act_mem_tb;

	localparam int wait_limit = 64;                     // cycles per apb access
	localparam int words = 2 * `ACT_HALF_ROWS;

	logic clk = 1'b0;
	logic reset = 1'b0;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [31:0] paddr = '0;
	logic [31:0] pwdata = '0;
	logic pready;
	logic [31:0] prdata;
	logic pslverr;
	logic wr_en = 1'b0;
	logic [`ACT_ROW_W-1:0] wr_addr = '0;
	act_word_pkg::act_word_u wr_word = '0;
	logic [`ACT_ADDR_W-1:0] out_ptr = '0;
	logic rd_en = 1'b0;
	logic [`ACT_ADDR_W-2:0] rd_addr = '0;
	logic [`ACT_ADDR_W-1:0] in_ptr = '0;
	act_ctrl_pkg::layer_mode_e mode = act_ctrl_pkg::MODE_FC;
	logic loading_in_parallel = 1'b0;
	act_word_pkg::act_word_u read_word;
	logic read_valid;

	logic arr_wr_on = 1'b0;                             // array traffic switches
	logic arr_rd_on = 1'b0;

	// reference model
	act_word_pkg::act_word_u model [words];
	logic rd_pend = 1'b0;
	act_word_pkg::act_word_u rd_exp;
	logic host_rd_phase = 1'b0;
	act_word_pkg::act_word_u host_exp;

	`include "act_mem_checks.svh"

	act_mem_top UUT (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_word(wr_word),
		.out_ptr(out_ptr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.in_ptr(in_ptr),
		.mode(mode),
		.loading_in_parallel(loading_in_parallel),
		.read_word(read_word),
		.read_valid(read_valid)
	);

	always #20 clk = ~clk;

	// start lane s lands in lane 0
	function automatic act_word_pkg::act_word_u rotate_lanes(input act_word_pkg::act_word_u w,
		input logic [`ACT_LANES_LOG-1:0] start);
		act_word_pkg::act_word_u r;
		logic [63:0] twice;
		twice = {w.raw, w.raw} >> (start * `ACT_LANE_W);
		r.raw = twice[31:0];
		return r;
	endfunction

	function automatic logic [31:0] rand_word_addr();
		logic [31:0] rnd;
		rnd = $urandom;
		return {22'd0, rnd[9:2], 2'b00};
	endfunction

	task automatic read_back_all();
		for (int i = 0; i < words; i++) begin
			apb_read(i * 4);
		end
	endtask

	////////////////////////////////////////////////////////////
	// array side traffic
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin : drive_array
		logic [31:0] rnd;
		rnd = $urandom;
		wr_en       <= arr_wr_on && rnd[0];
		wr_addr     <= rnd[8:2];
		out_ptr     <= rnd[18:9];
		wr_word.raw <= $urandom;
		rnd = $urandom;
		rd_en               <= arr_rd_on && (rnd[1:0] != 2'd0);    // mostly back to back
		in_ptr              <= rnd[11:2];
		loading_in_parallel <= rnd[12];
		case (rnd[14:13])
			2'd0: mode <= act_ctrl_pkg::MODE_FC;
			2'd1: mode <= act_ctrl_pkg::MODE_EWS;
			default: mode <= act_ctrl_pkg::MODE_CNN;
		endcase
		if (rnd[14] && !rnd[12]) begin
			rd_addr <= rnd[23:15];                      // lane address
		end else begin
			rd_addr <= {2'b00, rnd[21:15]};             // row index
		end
	end

	////////////////////////////////////////////////////////////
	// reference model, stepped between edges
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin : model_step
		logic access;
		logic addr_ok;
		logic exp_ready;
		logic exp_err;
		logic [`ACT_ROW_W-1:0] row;
		logic [`ACT_ADDR_W-2:0] lane_sum;
		if (!reset) begin
			rd_pend       = 1'b0;
			host_rd_phase = 1'b0;
		end else begin
			access  = psel && penable;
			addr_ok = (paddr[1:0] == 2'b00) && (paddr[31:`ACT_ADDR_W] == '0);
			check_flag("read_valid", read_valid, rd_pend);
			if (rd_pend) begin
				check_word(read_word, rd_exp);
			end
			exp_err   = access && !addr_ok && !host_rd_phase;
			exp_ready = host_rd_phase || exp_err ||
				(access && pwrite && !(wr_en && out_ptr[`ACT_ADDR_W-1] == paddr[`ACT_ADDR_W-1]));
			check_flag("pready", pready, exp_ready);
			if (host_rd_phase) begin
				check_resp(act_word_pkg::act_word_u'(prdata), pslverr, host_exp,
					act_ctrl_pkg::APB_OKAY);
			end else begin
				check_flag("pslverr", pslverr, exp_err);
			end
			// reads see the words before this edge's writes
			rd_pend = rd_en;
			if (rd_en && mode == act_ctrl_pkg::MODE_CNN && !loading_in_parallel) begin
				lane_sum = rd_addr + in_ptr[`ACT_ADDR_W-2:0];
				rd_exp   = rotate_lanes(model[{in_ptr[`ACT_ADDR_W-1], lane_sum[8:2]}],
					lane_sum[1:0]);
			end else if (rd_en) begin
				row    = rd_addr[`ACT_ROW_W-1:0] + in_ptr[`ACT_ADDR_W-2:`ACT_LANES_LOG];
				rd_exp = model[{in_ptr[`ACT_ADDR_W-1], row}];
			end
			if (host_rd_phase) begin
				host_rd_phase = 1'b0;
			end else if (access && addr_ok && !pwrite &&
				!(rd_en && in_ptr[`ACT_ADDR_W-1] == paddr[`ACT_ADDR_W-1])) begin
				host_rd_phase = 1'b1;                   // array read port was free
				host_exp      = model[paddr[`ACT_ADDR_W-1:2]];
			end
			if (wr_en) begin
				row = wr_addr + out_ptr[`ACT_ADDR_W-2:`ACT_LANES_LOG];
				model[{out_ptr[`ACT_ADDR_W-1], row}] = wr_word;
			end
			if (access && addr_ok && pwrite &&
				!(wr_en && out_ptr[`ACT_ADDR_W-1] == paddr[`ACT_ADDR_W-1])) begin
				model[paddr[`ACT_ADDR_W-1:2]] = act_word_pkg::act_word_u'(pwdata);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin : run_test
		logic [31:0] rnd;
		logic [31:0] addr;
		void'($urandom(32'hdfe7a9b0));
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < words; i++) begin
			apb_write(i * 4, $urandom);                 // every word known to the model
		end
		for (int i = 0; i < 120; i++) begin
			rnd = $urandom;
			if (rnd[0]) apb_write(rand_word_addr(), $urandom);
			else apb_read(rand_word_addr());
		end
		// misaligned and out of range accesses
		for (int i = 0; i < 24; i++) begin
			rnd = $urandom;
			if (rnd[0]) addr = {20'd0, rnd[11:2], 2'b01};
			else addr = {rnd[31:2], 2'b00} | 32'h0000_0400;
			if (rnd[1]) apb_write(addr, $urandom);
			else apb_read(addr);
		end
		read_back_all();
		arr_wr_on <= 1'b1;
		repeat (200) @(posedge clk);
		arr_wr_on <= 1'b0;
		read_back_all();
		arr_rd_on <= 1'b1;
		repeat (300) @(posedge clk);
		// host traffic against both array ports
		arr_wr_on <= 1'b1;
		for (int i = 0; i < 150; i++) begin
			rnd = $urandom;
			if (rnd[0]) apb_write(rand_word_addr(), $urandom);
			else apb_read(rand_word_addr());
		end
		arr_wr_on <= 1'b0;
		arr_rd_on <= 1'b0;
		read_back_all();
		repeat (2) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

// File: hdl/act_addr_decode.sv
`include "act_mem_params.svh"

module act_addr_decode (
	input  logic wr_en,
	input  logic [`ACT_ROW_W-1:0] wr_addr,
	input  logic [`ACT_ADDR_W-1:0] out_ptr,
	input  logic rd_en,
	input  logic [`ACT_ADDR_W-2:0] rd_addr,
	input  logic [`ACT_ADDR_W-1:0] in_ptr,
	input  act_ctrl_pkg::layer_mode_e mode,
	input  logic loading_in_parallel,
	output logic arr_wr_en0,
	output logic arr_wr_en1,
	output logic [`ACT_ROW_W-1:0] arr_wr_row,
	output logic arr_rd_en0,
	output logic arr_rd_en1,
	output logic [`ACT_ROW_W-1:0] arr_rd_row,
	output logic [`ACT_LANES_LOG-1:0] rd_rot
);

	logic wr_half;
	logic rd_half;
	logic lane_read;                                    // cnn read from any start lane
	logic [`ACT_ROW_W-1:0] rd_row_sum;
	logic [`ACT_ADDR_W-2:0] rd_lane_sum;

	assign wr_half = out_ptr[`ACT_ADDR_W-1];
	assign rd_half = in_ptr[`ACT_ADDR_W-1];

	////////////////////////////////////////////////////////////
	// writes
	////////////////////////////////////////////////////////////

	assign arr_wr_en0 = wr_en && !wr_half;
	assign arr_wr_en1 = wr_en && wr_half;
	assign arr_wr_row = wr_addr + out_ptr[`ACT_ADDR_W-2:`ACT_LANES_LOG];   // wraps in the half

	////////////////////////////////////////////////////////////
	// reads
	////////////////////////////////////////////////////////////

	assign lane_read = (mode == act_ctrl_pkg::MODE_CNN) && !loading_in_parallel;

	// row index plus pointer row
	assign rd_row_sum = rd_addr[`ACT_ROW_W-1:0] + in_ptr[`ACT_ADDR_W-2:`ACT_LANES_LOG];

	// lane address plus pointer row and lane
	assign rd_lane_sum = rd_addr + in_ptr[`ACT_ADDR_W-2:0];

	assign arr_rd_en0 = rd_en && !rd_half;
	assign arr_rd_en1 = rd_en && rd_half;

	always_comb begin
		if (lane_read) begin
			arr_rd_row = rd_lane_sum[`ACT_ADDR_W-2:`ACT_LANES_LOG];
			rd_rot     = rd_lane_sum[`ACT_LANES_LOG-1:0];
		end else begin
			arr_rd_row = rd_row_sum;
			rd_rot     = '0;                            // whole word
		end
	end

endmodule

// File: hdl/act_apb_decode.sv
`include "act_mem_params.svh"

module act_apb_decode (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic host_wr_en,
	output logic host_rd_en,
	output logic host_half,
	output logic [`ACT_ROW_W-1:0] host_row,
	output act_word_pkg::act_word_u host_wdata,
	input  logic host_wr_grant,
	input  logic host_rd_grant,
	input  act_word_pkg::act_word_u host_rdata
);

	logic access;
	logic addr_ok;
	logic rd_phase;         // read issued last cycle, data on host_rdata

	assign access  = psel && penable;
	assign addr_ok = (paddr[`ACT_LANES_LOG-1:0] == '0) && (paddr[31:`ACT_ADDR_W] == '0);

	// byte address maps straight onto the lane address
	assign host_half  = paddr[`ACT_ADDR_W-1];
	assign host_row   = paddr[`ACT_ADDR_W-2:`ACT_LANES_LOG];
	assign host_wdata = act_word_pkg::act_word_u'(pwdata);

	////////////////////////////////////////////////////////////
	// access phase
	////////////////////////////////////////////////////////////

	always_comb begin
		host_wr_en = 1'b0;
		host_rd_en = 1'b0;
		pready     = 1'b0;
		pslverr    = act_ctrl_pkg::APB_OKAY;
		prdata     = '0;
		if (rd_phase) begin
			pready = 1'b1;
			prdata = host_rdata.raw;
		end else if (access && !addr_ok) begin
			pready  = 1'b1;                             // no memory access
			pslverr = act_ctrl_pkg::APB_ERR;
		end else if (access && pwrite) begin
			host_wr_en = 1'b1;
			pready     = host_wr_grant;                 // stall while array writes
		end else if (access) begin
			host_rd_en = 1'b1;                          // wait for a free read port
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_phase <= 1'b0;
		end else begin
			rd_phase <= host_rd_en && host_rd_grant;
		end
	end

	// a refused request stays up on the same word until accepted
	a_wr_held: assert property (@(posedge clk) disable iff (!reset)
		host_wr_en && !host_wr_grant |=>
			host_wr_en && $stable(host_half) && $stable(host_row));
	a_rd_held: assert property (@(posedge clk) disable iff (!reset)
		host_rd_en && !host_rd_grant |=>
			host_rd_en && $stable(host_half) && $stable(host_row));

endmodule

// File: hdl/act_ctrl_pkg.sv
package act_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// layer modes
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		MODE_FC  = 3'd0,
		MODE_CNN = 3'd1,
		MODE_EWS = 3'd3
	} layer_mode_e;

	////////////////////////////////////////////////////////////
	// apb response
	////////////////////////////////////////////////////////////

	localparam logic APB_OKAY = 1'b0;
	localparam logic APB_ERR  = 1'b1;

endpackage

// File: hdl/act_mem_half.sv
`include "act_mem_params.svh"

module act_mem_half (
	input  logic clk,
	input  logic reset,
	input  logic arr_wr_en,
	input  logic [`ACT_ROW_W-1:0] arr_wr_row,
	input  act_word_pkg::act_word_u arr_wdata,
	input  logic arr_rd_en,
	input  logic [`ACT_ROW_W-1:0] arr_rd_row,
	input  logic host_wr_en,
	input  logic host_rd_en,
	input  logic [`ACT_ROW_W-1:0] host_row,
	input  act_word_pkg::act_word_u host_wdata,
	output logic host_wr_grant,
	output logic host_rd_grant,
	output act_word_pkg::act_word_u rdata
);

	act_word_pkg::act_word_u mem [`ACT_HALF_ROWS];
	act_word_pkg::act_word_u wdata;
	logic wr_issue;
	logic rd_issue;
	logic [`ACT_ROW_W-1:0] wr_row;
	logic [`ACT_ROW_W-1:0] rd_row;

	// array side always wins a port
	assign host_wr_grant = host_wr_en && !arr_wr_en;
	assign host_rd_grant = host_rd_en && !arr_rd_en;

	assign wr_issue = arr_wr_en || host_wr_grant;
	assign wr_row   = arr_wr_en ? arr_wr_row : host_row;
	assign wdata    = arr_wr_en ? arr_wdata : host_wdata;

	assign rd_issue = arr_rd_en || host_rd_grant;
	assign rd_row   = arr_rd_en ? arr_rd_row : host_row;

	always_ff @(posedge clk) begin
		if (wr_issue) begin
			mem[wr_row] <= wdata;
		end
	end

	// holds until the next issued read
	always_ff @(posedge clk) begin
		if (rd_issue) begin
			rdata <= mem[rd_row];
		end
	end

	a_one_host_req: assert property (@(posedge clk) disable iff (!reset)
		!(host_wr_en && host_rd_en));                   // host_row serves one transfer

endmodule

// File: hdl/act_mem_params.svh
`ifndef ACT_MEM_PARAMS_SVH
`define ACT_MEM_PARAMS_SVH

// one signed activation per lane
`define ACT_LANE_W 8
`define ACT_LANES 4
`define ACT_LANES_LOG 2

// lane address {half, row, lane}
`define ACT_ADDR_W 10
`define ACT_HALF_ROWS 128

// row field width inside one half
`define ACT_ROW_W (`ACT_ADDR_W - 1 - `ACT_LANES_LOG)

`endif

// File: hdl/act_mem_top.sv
`include "act_mem_params.svh"

module act_mem_top (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	output logic pready,
	output logic [31:0] prdata,
	output logic pslverr,
	input  logic wr_en,
	input  logic [`ACT_ROW_W-1:0] wr_addr,
	input  act_word_pkg::act_word_u wr_word,
	input  logic [`ACT_ADDR_W-1:0] out_ptr,
	input  logic rd_en,
	input  logic [`ACT_ADDR_W-2:0] rd_addr,
	input  logic [`ACT_ADDR_W-1:0] in_ptr,
	input  act_ctrl_pkg::layer_mode_e mode,
	input  logic loading_in_parallel,
	output act_word_pkg::act_word_u read_word,
	output logic read_valid
);

	logic host_wr_en;
	logic host_rd_en;
	logic host_half;
	logic [`ACT_ROW_W-1:0] host_row;
	act_word_pkg::act_word_u host_wdata;
	act_word_pkg::act_word_u host_rdata;
	logic wr_grant0;
	logic wr_grant1;
	logic rd_grant0;
	logic rd_grant1;
	logic arr_wr_en0;
	logic arr_wr_en1;
	logic [`ACT_ROW_W-1:0] arr_wr_row;
	logic arr_rd_en0;
	logic arr_rd_en1;
	logic [`ACT_ROW_W-1:0] arr_rd_row;
	logic [`ACT_LANES_LOG-1:0] rd_rot;
	act_word_pkg::act_word_u rdata0;
	act_word_pkg::act_word_u rdata1;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	act_apb_decode u_apb (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.host_wr_en(host_wr_en),
		.host_rd_en(host_rd_en),
		.host_half(host_half),
		.host_row(host_row),
		.host_wdata(host_wdata),
		.host_wr_grant(wr_grant0 || wr_grant1),     // only the addressed half can grant
		.host_rd_grant(rd_grant0 || rd_grant1),
		.host_rdata(host_rdata)
	);

	assign host_rdata = host_half ? rdata1 : rdata0;

	act_addr_decode u_addr (
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.out_ptr(out_ptr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.in_ptr(in_ptr),
		.mode(mode),
		.loading_in_parallel(loading_in_parallel),
		.arr_wr_en0(arr_wr_en0),
		.arr_wr_en1(arr_wr_en1),
		.arr_wr_row(arr_wr_row),
		.arr_rd_en0(arr_rd_en0),
		.arr_rd_en1(arr_rd_en1),
		.arr_rd_row(arr_rd_row),
		.rd_rot(rd_rot)
	);

	////////////////////////////////////////////////////////////
	// storage, ping-pong halves
	////////////////////////////////////////////////////////////

	act_mem_half u_half0 (
		.clk(clk),
		.reset(reset),
		.arr_wr_en(arr_wr_en0),
		.arr_wr_row(arr_wr_row),
		.arr_wdata(wr_word),
		.arr_rd_en(arr_rd_en0),
		.arr_rd_row(arr_rd_row),
		.host_wr_en(host_wr_en && !host_half),
		.host_rd_en(host_rd_en && !host_half),
		.host_row(host_row),
		.host_wdata(host_wdata),
		.host_wr_grant(wr_grant0),
		.host_rd_grant(rd_grant0),
		.rdata(rdata0)
	);

	act_mem_half u_half1 (
		.clk(clk),
		.reset(reset),
		.arr_wr_en(arr_wr_en1),
		.arr_wr_row(arr_wr_row),
		.arr_wdata(wr_word),
		.arr_rd_en(arr_rd_en1),
		.arr_rd_row(arr_rd_row),
		.host_wr_en(host_wr_en && host_half),
		.host_rd_en(host_rd_en && host_half),
		.host_row(host_row),
		.host_wdata(host_wdata),
		.host_wr_grant(wr_grant1),
		.host_rd_grant(rd_grant1),
		.rdata(rdata1)
	);

	////////////////////////////////////////////////////////////
	// result
	////////////////////////////////////////////////////////////

	act_read_align u_align (
		.clk(clk),
		.reset(reset),
		.rd_en(rd_en),
		.rd_half(in_ptr[`ACT_ADDR_W-1]),
		.rd_rot(rd_rot),
		.rdata0(rdata0),
		.rdata1(rdata1),
		.read_word(read_word),
		.read_valid(read_valid)
	);

endmodule

// File: hdl/act_read_align.sv
`include "act_mem_params.svh"

module act_read_align (
	input  logic clk,
	input  logic reset,
	input  logic rd_en,
	input  logic rd_half,
	input  logic [`ACT_LANES_LOG-1:0] rd_rot,
	input  act_word_pkg::act_word_u rdata0,
	input  act_word_pkg::act_word_u rdata1,
	output act_word_pkg::act_word_u read_word,
	output logic read_valid
);

	logic half_q;
	logic [`ACT_LANES_LOG-1:0] rot_q;
	logic [`ACT_LANES_LOG-1:0] idx;
	act_word_pkg::act_word_u src;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			read_valid <= 1'b0;
			half_q     <= 1'b0;
			rot_q      <= '0;
		end else begin
			read_valid <= rd_en;
			if (rd_en) begin
				half_q <= rd_half;
				rot_q  <= rd_rot;
			end
		end
	end

	assign src = half_q ? rdata1 : rdata0;

	// out lane j takes stored lane (start + j) mod lanes
	always_comb begin
		idx = '0;
		for (int j = 0; j < `ACT_LANES; j++) begin
			idx = rot_q + j[`ACT_LANES_LOG-1:0];
			read_word.lanes[j] = src.lanes[idx];
		end
	end

endmodule

// File: hdl/act_word_pkg.sv
`include "act_mem_params.svh"

package act_word_pkg;

	////////////////////////////////////////////////////////////
	// activation data
	////////////////////////////////////////////////////////////

	typedef logic signed [`ACT_LANE_W-1:0] act_lane_t;

	// one buffer word, seen per lane by the array and as a
	// plain 32-bit value by the host port
	typedef union packed {
		act_lane_t [`ACT_LANES-1:0] lanes;              // lane 0 in the low byte
		logic [`ACT_LANES*`ACT_LANE_W-1:0] raw;
	} act_word_u;

endpackage

// File: project.f
+incdir+hdl
+incdir+bench
hdl/act_word_pkg.sv
hdl/act_ctrl_pkg.sv
hdl/act_apb_decode.sv
hdl/act_addr_decode.sv
hdl/act_mem_half.sv
hdl/act_read_align.sv
hdl/act_mem_top.sv
bench/act_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the activation buffer testbench with verilator, run it, judge the log
verilator --binary --timing --assert --top-module act_mem_tb -f project.f -o act_mem_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/act_mem_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; } \
	|| echo "simulation passed"
